// File: hw/conv_pkg.sv
package conv_pkg;

  // pixel and weight width
  localparam int DWIDTH = 8;
  // 2*DWIDTH product plus 4 guard bits for up to 16 taps
  localparam int AWIDTH = 2 * DWIDTH + 4;
  localparam int LSEL_W = 4;
  localparam int COL_W = 8;

  typedef logic signed [DWIDTH-1:0]   pixel_t;
  typedef logic signed [DWIDTH-1:0]   weight_t;
  typedef logic signed [2*DWIDTH-1:0] prod_t;
  typedef logic signed [AWIDTH-1:0]   acc_t;

  // one-based line select, 0 means none
  typedef logic [LSEL_W-1:0] lsel_t;
  // column, row and address counters
  typedef logic [COL_W-1:0]  col_t;

  typedef enum logic [1:0] {IDLE, FILL, SWEEP, DRAIN} ctrl_state_t;

  // controller to window buffer, one request per cycle
  typedef struct packed {
    logic   we;
    lsel_t  wsel;
    lsel_t  rsel;
    col_t   addr;
    pixel_t wdata;
  } win_req_t;

endpackage

// File: hw/line_mem.sv
`timescale 1ns/10ps

module line_mem #(
  parameter int DW = 8,
  parameter int AW = 3
) (
  input  logic          clk,
  input  logic          xrst,
  input  logic          mem_we,
  input  logic [AW-1:0] mem_addr,
  input  logic [DW-1:0] mem_wdata,
  output logic [DW-1:0] mem_rdata
);

  logic [DW-1:0] mem [0:2**AW-1];

  always_ff @(posedge clk) begin
    if (mem_we) begin
      mem[mem_addr] <= mem_wdata;
    end
  end

  // read data lags the address by one cycle
  always_ff @(posedge clk) begin
    if (!xrst) begin
      mem_rdata <= '0;
    end else begin
      mem_rdata <= mem[mem_addr];
    end
  end

endmodule

// File: hw/window_buffer.sv
`timescale 1ns/10ps

module window_buffer #(
  parameter int FIL = 3,
  parameter int IMG = 8
) (
  input  logic               clk,
  input  logic               xrst,
  input  conv_pkg::win_req_t req,
  output conv_pkg::pixel_t   window [FIL*FIL-1:0]
);

  localparam int BUFLINE = FIL + 1;
  localparam int AW = $clog2(IMG);
  localparam conv_pkg::lsel_t NLINE = conv_pkg::lsel_t'(BUFLINE);

  logic [BUFLINE-1:0] line_we;
  conv_pkg::pixel_t   rdata [BUFLINE-1:0];
  // newest column entering each window row
  conv_pkg::pixel_t   col_in [FIL-1:0];

  ////////////////////////////////////////////////////////////
  // line memories
  ////////////////////////////////////////////////////////////

  for (genvar i = 0; i < BUFLINE; i++) begin : g_line
    assign line_we[i] = req.we && (req.wsel == conv_pkg::lsel_t'(i + 1));

    line_mem #(
      .DW (conv_pkg::DWIDTH),
      .AW (AW)
    ) u_line (
      .clk       (clk),
      .xrst      (xrst),
      .mem_we    (line_we[i]),
      .mem_addr  (req.addr[AW-1:0]),
      .mem_wdata (req.wdata),
      .mem_rdata (rdata[i])
    );
  end

  ////////////////////////////////////////////////////////////
  // row rotation
  ////////////////////////////////////////////////////////////

  // window row i reads line (i + rsel - 1) mod BUFLINE, rsel 0 feeds zeros
  always_comb begin
    for (int i = 0; i < FIL; i++) begin
      col_in[i] = '0;
      for (int k = 0; k < BUFLINE; k++) begin
        if (req.rsel == conv_pkg::lsel_t'(k + 1)) begin
          col_in[i] = rdata[(i + k) % BUFLINE];
        end
      end
    end
  end

  ////////////////////////////////////////////////////////////
  // window shift registers
  ////////////////////////////////////////////////////////////

  // column FIL-1 takes the new pixel, older ones move toward column 0
  always_ff @(posedge clk) begin
    if (!xrst) begin
      for (int n = 0; n < FIL * FIL; n++) begin
        window[n] <= '0;
      end
    end else begin
      for (int i = 0; i < FIL; i++) begin
        for (int j = 0; j < FIL - 1; j++) begin
          window[FIL*i+j] <= window[FIL*i+j+1];
        end
        window[FIL*i+FIL-1] <= col_in[i];
      end
    end
  end

  assert property (@(posedge clk) disable iff (!xrst) req.wsel <= NLINE)
    else $error("write line select %0d beyond %0d lines", req.wsel, BUFLINE);

endmodule

// File: hw/weight_store.sv
`timescale 1ns/10ps

module weight_store #(
  parameter int FIL = 3
) (
  input  logic                       clk,
  input  logic                       xrst,
  input  logic                       w_we,
  input  logic [$clog2(FIL*FIL)-1:0] w_addr,
  input  conv_pkg::weight_t          w_data,
  output conv_pkg::weight_t          kernel [FIL*FIL-1:0]
);

  localparam int NTAP = FIL * FIL;

  // index FIL*i+j pairs with window row i, column j
  always_ff @(posedge clk) begin
    if (!xrst) begin
      for (int n = 0; n < NTAP; n++) begin
        kernel[n] <= '0;
      end
    end else if (w_we) begin
      kernel[w_addr] <= w_data;
    end
  end

  assert property (@(posedge clk) disable iff (!xrst) w_we |-> (w_addr < NTAP))
    else $error("weight address %0d out of range", w_addr);

endmodule

// File: hw/window_mac.sv
`timescale 1ns/10ps

module window_mac #(
  parameter int FIL = 3
) (
  input  logic              clk,
  input  logic              xrst,
  input  logic              win_valid,
  input  conv_pkg::pixel_t  window [FIL*FIL-1:0],
  input  conv_pkg::weight_t kernel [FIL*FIL-1:0],
  output logic              res_valid,
  output conv_pkg::acc_t    res_data
);

  localparam int NTAP = FIL * FIL;

  conv_pkg::prod_t prod [NTAP-1:0];
  logic            prod_valid;
  conv_pkg::acc_t  sum;

  ////////////////////////////////////////////////////////////
  // stage one, products
  ////////////////////////////////////////////////////////////

  always_ff @(posedge clk) begin
    if (win_valid) begin
      for (int i = 0; i < NTAP; i++) begin
        prod[i] <= conv_pkg::prod_t'(window[i]) * kernel[i];
      end
    end
  end

  ////////////////////////////////////////////////////////////
  // stage two, sum
  ////////////////////////////////////////////////////////////

  // products are sign extended into the accumulator width
  always_comb begin
    sum = '0;
    for (int i = 0; i < NTAP; i++) begin
      sum = sum + conv_pkg::acc_t'(prod[i]);
    end
  end

  always_ff @(posedge clk) begin
    if (prod_valid) begin
      res_data <= sum;
    end
  end

  // valid follows the data two cycles behind win_valid
  always_ff @(posedge clk) begin
    if (!xrst) begin
      prod_valid <= 1'b0;
      res_valid  <= 1'b0;
    end else begin
      prod_valid <= win_valid;
      res_valid  <= prod_valid;
    end
  end

endmodule

// File: hw/conv_ctrl.sv
`timescale 1ns/10ps

module conv_ctrl #(
  parameter int FIL = 3,
  parameter int IMG = 8
) (
  input  logic               clk,
  input  logic               xrst,
  input  logic               start,
  input  logic               pix_valid,
  input  conv_pkg::pixel_t   pix_data,
  output conv_pkg::win_req_t req,
  output logic               win_valid,
  output logic               busy
);

  localparam int BUFLINE = FIL + 1;
  // read, window register, product, sum
  localparam int DRAIN_LEN = 4;
  localparam conv_pkg::col_t LAST_COL = conv_pkg::col_t'(IMG - 1);
  localparam conv_pkg::col_t FIRST_FULL = conv_pkg::col_t'(FIL - 1);
  localparam conv_pkg::lsel_t NLINE = conv_pkg::lsel_t'(BUFLINE);
  localparam conv_pkg::lsel_t TOP_OFS = conv_pkg::lsel_t'(BUFLINE - FIL + 1);

  conv_pkg::ctrl_state_t state;
  conv_pkg::col_t        col;
  conv_pkg::col_t        scol;
  conv_pkg::col_t        row;
  conv_pkg::lsel_t       wline;
  conv_pkg::lsel_t       next_wline;
  conv_pkg::lsel_t       top_sum;
  conv_pkg::lsel_t       top;
  logic [1:0]            dcnt;
  logic [1:0]            tag;
  logic                  accept;

  // start wins over a pixel in the same cycle
  assign accept = pix_valid && (state == conv_pkg::FILL ||
                                (state == conv_pkg::IDLE && !start));

  assign next_wline = (wline == NLINE - 1'b1) ? '0 : wline + 1'b1;

  // top line of the window is (row - FIL + 1) mod BUFLINE
  assign top_sum = wline + TOP_OFS;
  assign top     = (top_sum >= NLINE) ? top_sum - NLINE : top_sum;

  always_comb begin
    req       = '0;
    req.wdata = pix_data;
    req.we    = accept;
    req.wsel  = accept ? wline + 1'b1 : '0;
    req.addr  = (state == conv_pkg::SWEEP) ? scol : col;
    // rotation held through DRAIN for the last read in flight
    if (state == conv_pkg::SWEEP || state == conv_pkg::DRAIN) begin
      req.rsel = top + 1'b1;
    end
  end

  ////////////////////////////////////////////////////////////
  // sweep FSM
  ////////////////////////////////////////////////////////////

  always_ff @(posedge clk) begin
    if (!xrst) begin
      state <= conv_pkg::IDLE;
      col   <= '0;
      scol  <= '0;
      row   <= '0;
      wline <= '0;
      dcnt  <= '0;
      busy  <= 1'b0;
    end else begin
      case (state)
        conv_pkg::IDLE, conv_pkg::FILL: begin
          if (state == conv_pkg::IDLE) begin
            busy <= 1'b0;
          end
          if (state == conv_pkg::IDLE && start) begin
            row   <= '0;
            wline <= '0;
            col   <= '0;
          end else if (accept) begin
            if (col == LAST_COL) begin
              col  <= '0;
              busy <= 1'b1;
              if (row >= FIRST_FULL) begin
                state <= conv_pkg::SWEEP;
                scol  <= '0;
              end else begin
                // too few lines for a window yet
                state <= conv_pkg::IDLE;
                row   <= row + 1'b1;
                wline <= next_wline;
              end
            end else begin
              col   <= col + 1'b1;
              state <= conv_pkg::FILL;
            end
          end
        end
        conv_pkg::SWEEP: begin
          if (scol == LAST_COL) begin
            state <= conv_pkg::DRAIN;
            dcnt  <= '0;
          end else begin
            scol <= scol + 1'b1;
          end
        end
        conv_pkg::DRAIN: begin
          if (dcnt == 2'(DRAIN_LEN - 1)) begin
            state <= conv_pkg::IDLE;
            busy  <= 1'b0;
            if (row == LAST_COL) begin
              row   <= '0;
              wline <= '0;
            end else begin
              row   <= row + 1'b1;
              wline <= next_wline;
            end
          end else begin
            dcnt <= dcnt + 1'b1;
          end
        end
        default: state <= conv_pkg::IDLE;
      endcase
    end
  end

  // tag line marks the address of each full window, two cycles ahead
  always_ff @(posedge clk) begin
    if (!xrst) begin
      tag <= '0;
    end else begin
      tag <= {tag[0], (state == conv_pkg::SWEEP && scol >= FIRST_FULL)};
    end
  end

  assign win_valid = tag[1];

  assert property (@(posedge clk) disable iff (!xrst) !(pix_valid && busy))
    else $error("pixel strobe while busy");

  assert property (@(posedge clk) disable iff (!xrst)
    win_valid |-> (state == conv_pkg::SWEEP || state == conv_pkg::DRAIN))
    else $error("window valid outside a sweep");

endmodule

// File: hw/conv_top.sv
`timescale 1ns/10ps

module conv_top #(
  parameter int FIL = 3,
  parameter int IMG = 8
) (
  input  logic                       clk,
  input  logic                       xrst,
  input  logic                       w_we,
  input  logic [$clog2(FIL*FIL)-1:0] w_addr,
  input  conv_pkg::weight_t          w_data,
  input  logic                       pix_valid,
  input  conv_pkg::pixel_t           pix_data,
  input  logic                       start,
  output logic                       busy,
  output logic                       res_valid,
  output conv_pkg::acc_t             res_data
);

  conv_pkg::win_req_t req;
  conv_pkg::pixel_t   window [FIL*FIL-1:0];
  conv_pkg::weight_t  kernel [FIL*FIL-1:0];
  logic               win_valid;

  conv_ctrl #(
    .FIL (FIL),
    .IMG (IMG)
  ) u_ctrl (
    .clk       (clk),
    .xrst      (xrst),
    .start     (start),
    .pix_valid (pix_valid),
    .pix_data  (pix_data),
    .req       (req),
    .win_valid (win_valid),
    .busy      (busy)
  );

  // windowing path and weight store side by side
  window_buffer #(
    .FIL (FIL),
    .IMG (IMG)
  ) u_wbuf (
    .clk    (clk),
    .xrst   (xrst),
    .req    (req),
    .window (window)
  );

  weight_store #(
    .FIL (FIL)
  ) u_wstore (
    .clk    (clk),
    .xrst   (xrst),
    .w_we   (w_we),
    .w_addr (w_addr),
    .w_data (w_data),
    .kernel (kernel)
  );

  window_mac #(
    .FIL (FIL)
  ) u_mac (
    .clk       (clk),
    .xrst      (xrst),
    .win_valid (win_valid),
    .window    (window),
    .kernel    (kernel),
    .res_valid (res_valid),
    .res_data  (res_data)
  );

endmodule

// File: verif/tb_conv_top.sv
`timescale 1ns/10ps

module tb_conv_top;

  localparam int FIL = 3;
  localparam int IMG = 8;
  localparam int NTAP = FIL * FIL;
  localparam int WA_W = $clog2(NTAP);
  localparam int NOUT = IMG - FIL + 1;
  localparam int EXP_MAX = 256;
  localparam int TIMEOUT = 200;

  logic              clk;
  logic              xrst;
  logic              w_we;
  logic [WA_W-1:0]   w_addr;
  conv_pkg::weight_t w_data;
  logic              pix_valid;
  conv_pkg::pixel_t  pix_data;
  logic              start;
  logic              busy;
  logic              res_valid;
  conv_pkg::acc_t    res_data;

  // stimulus copies for the reference model
  conv_pkg::pixel_t  img [0:IMG-1][0:IMG-1];
  conv_pkg::weight_t kern [0:NTAP-1];

  // expected results in arrival order
  conv_pkg::acc_t exp_mem [0:EXP_MAX-1];
  int exp_wr;
  int exp_rd;
  int res_cnt;
  int val_errs;
  int extra_errs;
  int tb_errs;
  int tests_run;
  int seed;
  bit timed_out;

  initial clk = 1'b0;
  always #10 clk = ~clk;

  conv_top #(
    .FIL (FIL),
    .IMG (IMG)
  ) UUT (
    .clk       (clk),
    .xrst      (xrst),
    .w_we      (w_we),
    .w_addr    (w_addr),
    .w_data    (w_data),
    .pix_valid (pix_valid),
    .pix_data  (pix_data),
    .start     (start),
    .busy      (busy),
    .res_valid (res_valid),
    .res_data  (res_data)
  );

  ////////////////////////////////////////////////////////////
  // result checking
  ////////////////////////////////////////////////////////////

  always @(posedge clk) begin
    if (!xrst) begin
      exp_rd  <= 0;
      res_cnt <= 0;
    end else if (res_valid) begin
      exp_rd  <= exp_rd + 1;
      res_cnt <= res_cnt + 1;
    end
  end

  // each result against the oldest expected value
  assert property (@(negedge clk) disable iff (!xrst)
    (res_valid && exp_rd < exp_wr) |-> (res_data == exp_mem[exp_rd]))
  else begin
    $display("Error at %0t: res_data = %0d, expected %0d", $time, res_data, exp_mem[exp_rd]);
    val_errs++;
  end

  assert property (@(negedge clk) disable iff (!xrst) res_valid |-> (exp_rd < exp_wr))
  else begin
    $display("at %0t a result came out that no window called for", $time);
    extra_errs++;
  end

  function automatic int error_total();
    return tb_errs + val_errs + extra_errs;
  endfunction

  // sum of products over the window whose newest pixel is (r, c)
  function automatic conv_pkg::acc_t window_sum(input int r, input int c);
    int s;
    s = 0;
    for (int i = 0; i < FIL; i++) begin
      for (int j = 0; j < FIL; j++) begin
        s += int'(img[r-FIL+1+i][c-FIL+1+j]) * int'(kern[FIL*i+j]);
      end
    end
    return conv_pkg::acc_t'(s);
  endfunction

  ////////////////////////////////////////////////////////////
  // stimulus
  ////////////////////////////////////////////////////////////

  task automatic wait_busy(input logic level, input int r);
    int n;
    n = 0;
    @(negedge clk);
    while (busy !== level && n < TIMEOUT) begin
      @(negedge clk);
      n++;
    end
    if (busy !== level) begin
      $display("busy never went %s after row %0d", level ? "high" : "low", r);
      tb_errs++;
      timed_out = 1'b1;
    end
  endtask

  task automatic write_kernel();
    for (int n = 0; n < NTAP; n++) begin
      @(posedge clk);
      w_we   <= 1'b1;
      w_addr <= WA_W'(n);
      w_data <= kern[n];
    end
    @(posedge clk);
    w_we <= 1'b0;
  endtask

  task automatic send_row(input int r);
    int first;
    int exp_n;
    first = res_cnt;
    exp_n = (r >= FIL - 1) ? NOUT : 0;
    for (int c = FIL - 1; c < IMG && r >= FIL - 1; c++) begin
      exp_mem[exp_wr] = window_sum(r, c);
      exp_wr++;
    end
    for (int c = 0; c < IMG; c++) begin
      @(posedge clk);
      pix_valid <= 1'b1;
      pix_data  <= img[r][c];
    end
    @(posedge clk);
    pix_valid <= 1'b0;
    wait_busy(1'b1, r);
    if (!timed_out) begin
      wait_busy(1'b0, r);
    end
    assert (res_cnt - first == exp_n)
    else begin
      $display("Error at %0t: results of row %0d = %0d, expected %0d",
               $time, r, res_cnt - first, exp_n);
      tb_errs++;
    end
  endtask

  task automatic run_image(input int id, input string name);
    int errs0;
    int res0;
    errs0 = error_total();
    res0  = res_cnt;
    write_kernel();
    @(posedge clk);
    start <= 1'b1;
    @(posedge clk);
    start <= 1'b0;
    for (int r = 0; r < IMG && !timed_out; r++) begin
      send_row(r);
    end
    assert (exp_rd == exp_wr)
    else begin
      $display("%0d expected results never came out", exp_wr - exp_rd);
      tb_errs++;
    end
    tests_run++;
    $display("test %0d %s: %0d results, %0d errors",
             id, name, res_cnt - res0, error_total() - errs0);
  endtask

  task automatic fill_image(input bit rnd, input int v);
    for (int r = 0; r < IMG; r++) begin
      for (int c = 0; c < IMG; c++) begin
        img[r][c] = rnd ? conv_pkg::pixel_t'($random(seed)) : conv_pkg::pixel_t'(v);
      end
    end
  endtask

  task automatic fill_kernel(input bit rnd, input int v);
    for (int n = 0; n < NTAP; n++) begin
      kern[n] = rnd ? conv_pkg::weight_t'($random(seed)) : conv_pkg::weight_t'(v);
    end
  endtask

  initial begin
    seed       = 82711;
    xrst       = 1'b0;
    w_we       = 1'b0;
    w_addr     = '0;
    w_data     = '0;
    pix_valid  = 1'b0;
    pix_data   = '0;
    start      = 1'b0;
    exp_wr     = 0;
    tb_errs    = 0;
    val_errs   = 0;
    extra_errs = 0;
    tests_run  = 0;
    timed_out  = 1'b0;
    repeat (5) @(posedge clk);
    xrst <= 1'b1;
    @(negedge clk);
    assert (busy == 1'b0)
    else begin
      $display("Error at %0t: busy = %b, expected 0", $time, busy);
      tb_errs++;
    end
    assert (res_valid == 1'b0)
    else begin
      $display("Error at %0t: res_valid = %b, expected 0", $time, res_valid);
      tb_errs++;
    end

    // single 1 at the centre passes the middle pixel through
    fill_kernel(1'b0, 0);
    kern[NTAP/2] = conv_pkg::weight_t'(1);
    fill_image(1'b1, 0);
    run_image(1, "centre tap kernel");
    if (!timed_out) begin
      fill_kernel(1'b1, 0);
      fill_image(1'b1, 0);
      run_image(2, "random image and kernel");
    end
    if (!timed_out) begin
      fill_kernel(1'b1, 0);
      fill_image(1'b1, 0);
      // an abandoned image leaves the row counter part way down
      send_row(0);
      send_row(1);
      run_image(3, "restart with new kernel");
    end
    if (!timed_out) begin
      fill_kernel(1'b0, -128);
      fill_image(1'b0, -128);
      run_image(4, "pixels -128, weights -128");
    end
    if (!timed_out) begin
      fill_kernel(1'b0, -128);
      fill_image(1'b0, 127);
      run_image(5, "pixels 127, weights -128");
    end

    $display("tests %0d, results %0d of %0d, errors %0d",
             tests_run, res_cnt, exp_wr, error_total());
    if (error_total() == 0) begin
      $display("Done: no errors");
    end else begin
      $display("Done: errors found");
    end
    $finish;
  end

endmodule

// File: filelist.f
hw/conv_pkg.sv
hw/line_mem.sv
hw/window_buffer.sv
hw/weight_store.sv
hw/window_mac.sv
hw/conv_ctrl.sv
hw/conv_top.sv
verif/tb_conv_top.sv

// File: run.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --timescale 1ns/10ps \
  -f filelist.f --top-module tb_conv_top

status=0
./obj_dir/Vtb_conv_top > sim.log 2>&1 || status=$?
cat sim.log

if grep -q "Done: errors found" sim.log; then
  exit 1
fi
exit "$status"
